/* sources.f */
logic/dsp_pkg.sv
logic/ctrl_pkg.sv
logic/cordic_rotator.sv
logic/tone_generator.sv
logic/tone_bank.sv
logic/tone_mixer.sv
logic/dac_router.sv
logic/capture_buffer.sv
logic/uberclock_top.sv
testbench/tb_clock_gen.sv
testbench/tb_uberclock.sv

/* Bender.yml */
package:
  name: uberclock

sources:
  - logic/dsp_pkg.sv
  - logic/ctrl_pkg.sv
  - logic/cordic_rotator.sv
  - logic/tone_generator.sv
  - logic/tone_bank.sv
  - logic/tone_mixer.sv
  - logic/dac_router.sv
  - logic/capture_buffer.sv
  - logic/uberclock_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_uberclock.sv

/* testbench/tb_uberclock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uberclock;

    localparam int CAP_CYCLES = ctrl_pkg::CAP_DEPTH * dsp_pkg::DECIM;
    // tone pipe, strobe wait, mixer and router, with room to spare
    localparam int SETTLE = dsp_pkg::CORDIC_LATENCY + 2 * dsp_pkg::DECIM + 8;
    // reset, adc, dc tone, mixer, three captures, two readbacks
    localparam int TEST_CYCLES = 64 + 64 + 2 * SETTLE + SETTLE + 64
        + 3 * (SETTLE + CAP_CYCLES) + 2 * ctrl_pkg::CAP_DEPTH;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 2000;
    localparam longint UNITY = longint'(1) << dsp_pkg::GAIN_SHIFT;

    logic               sys_clk;
    logic               rst;
    dsp_pkg::phase_t    phase_inc [dsp_pkg::N_TONES];
    dsp_pkg::mag_t      mag       [dsp_pkg::N_TONES];
    dsp_pkg::gain_t     gain      [dsp_pkg::N_TONES];
    dsp_pkg::shift_t    final_shift;
    dsp_pkg::adc_word_t adc_ch0;
    dsp_pkg::adc_word_t adc_ch1;
    ctrl_pkg::dac_src_e dac_sel_ch1;
    ctrl_pkg::dac_src_e dac_sel_ch2;
    ctrl_pkg::cap_src_e cap_sel;
    logic               cap_arm;
    ctrl_pkg::cap_idx_t cap_idx;
    logic               ce;
    dsp_pkg::dac_word_t da1_data;
    dsp_pkg::dac_word_t da2_data;
    logic               cap_done;
    dsp_pkg::sample_t   cap_data;

    logic [31:0]        lcg_state = 32'hf721937b;
    dsp_pkg::sample_t   cap_copy [ctrl_pkg::CAP_DEPTH];

    tb_clock_gen u_clk (
        .o_sys_clk (sys_clk),
        .o_rst     (rst)
    );

    uberclock_top u_dut (
        .i_sys_clk      (sys_clk),
        .i_rst          (rst),
        .i_phase_inc    (phase_inc),
        .i_mag          (mag),
        .i_gain         (gain),
        .i_final_shift  (final_shift),
        .i_adc_data_ch0 (adc_ch0),
        .i_adc_data_ch1 (adc_ch1),
        .i_dac_sel_ch1  (dac_sel_ch1),
        .i_dac_sel_ch2  (dac_sel_ch2),
        .i_cap_sel      (cap_sel),
        .i_cap_arm      (cap_arm),
        .i_cap_idx      (cap_idx),
        .o_ce           (ce),
        .o_da1_data     (da1_data),
        .o_da2_data     (da2_data),
        .o_cap_done     (cap_done),
        .o_cap_data     (cap_data)
    );

    // ------------------------------
    // helpers and reference model
    // ------------------------------

    // numerical recipes constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic longint abs_value(input longint v);
        return (v < 0) ? -v : v;
    endfunction

    // cos(0) = 1, so mag x16 x gain over 2^30
    function automatic longint dc_sample(input longint m, input longint g);
        return (m * 16 * g) >>> dsp_pkg::GAIN_SHIFT;
    endfunction

    // top 14 of 16 sample bits, mid-scale offset, wrap to 14 bits
    function automatic longint tone_code(input longint s);
        return ((s >>> 2) + dsp_pkg::DAC_OFFSET) & 64'h3fff;
    endfunction

    // offset binary to signed, x4 into the 14 bit frame
    function automatic longint adc_code(input longint a);
        return ((a - 2048) * 4 + dsp_pkg::DAC_OFFSET) & 64'h3fff;
    endfunction

    function automatic longint mix_value(input longint sum, input int shift);
        longint v;
        v = (sum >>> dsp_pkg::MIX_DROP) <<< shift;
        if (v > 8191)
            return 8191;
        else if (v < -8192)
            return -8192;
        return v;
    endfunction

    task automatic compare_value(input string what, input longint actual,
                                 input longint expected, input longint tol);
        if (abs_value(actual - expected) > tol) begin
            $display("** Error at %0t: %s, got %0d, expected %0d within %0d",
                     $time, what, actual, expected, tol);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(negedge sys_clk);
    endtask

    // falling edges until the strobe is seen, bounded
    task automatic wait_strobe(output int cycles);
        cycles = 0;
        do begin
            step(1);
            cycles++;
        end while (!ce && cycles < 4 * dsp_pkg::DECIM);
        if (!ce) begin
            $display("sample strobe did not pulse within %0d cycles", cycles);
            $display("RESULT: FAIL");
            $fatal(1, "strobe missing");
        end
    endtask

    // one-cycle arm pulse, then wait for the buffer to fill
    task automatic arm_capture(output int cycles);
        cap_arm = 1'b1;
        step(1);
        cap_arm = 1'b0;
        cycles  = 1;
        compare_value("done cleared by arm", cap_done, 0, 0);
        while (!cap_done && cycles < CAP_CYCLES + 4 * dsp_pkg::DECIM) begin
            step(1);
            cycles++;
        end
        if (!cap_done) begin
            $display("capture did not complete after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $fatal(1, "capture stuck");
        end
        // first write lands 2 to 9 cycles after the arm edge
        compare_value("capture fill time", cycles, CAP_CYCLES - 2, 4);
    endtask

    // readback is combinational, settled by the next falling edge
    task automatic read_capture();
        for (int i = 0; i < ctrl_pkg::CAP_DEPTH; i++) begin
            cap_idx = ctrl_pkg::cap_idx_t'(i);
            step(1);
            cap_copy[i] = cap_data;
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic test_reset();
        int cycles;
        // still inside reset
        compare_value("ch1 in reset", da1_data, dsp_pkg::DAC_OFFSET, 0);
        compare_value("ch2 in reset", da2_data, dsp_pkg::DAC_OFFSET, 0);
        compare_value("done in reset", cap_done, 0, 0);
        if (rst)
            @(negedge rst);
        compare_value("ch1 at release", da1_data, dsp_pkg::DAC_OFFSET, 0);
        compare_value("ch2 at release", da2_data, dsp_pkg::DAC_OFFSET, 0);
        compare_value("done at release", cap_done, 0, 0);
        wait_strobe(cycles);
        compare_value("first strobe delay", cycles, dsp_pkg::DECIM, 0);
        for (int i = 0; i < 4; i++) begin
            wait_strobe(cycles);
            compare_value("strobe spacing", cycles, dsp_pkg::DECIM, 0);
        end
    endtask

    task automatic test_adc_passthrough();
        dsp_pkg::adc_word_t a0;
        dsp_pkg::adc_word_t a1;
        dac_sel_ch1 = ctrl_pkg::SRC_ADC0;
        dac_sel_ch2 = ctrl_pkg::SRC_ADC1;
        for (int i = 0; i < 16; i++) begin
            a0      = dsp_pkg::adc_word_t'(next_random() >> 20);
            a1      = dsp_pkg::adc_word_t'(next_random() >> 20);
            adc_ch0 = a0;
            adc_ch1 = a1;
            // conditioning register, then output register
            step(2);
            compare_value("adc0 on ch1", da1_data, adc_code(a0), 0);
            compare_value("adc1 on ch2", da2_data, adc_code(a1), 0);
        end
    endtask

    task automatic test_dc_tone();
        dsp_pkg::mag_t m;
        longint        g;
        longint        tol;
        m            = dsp_pkg::mag_t'(next_random() >> 20);
        phase_inc[0] = '0;
        mag[0]       = m;
        dac_sel_ch1  = ctrl_pkg::SRC_TONE0;
        // unity, then half gain
        for (int h = 0; h < 2; h++) begin
            g       = UNITY >> h;
            gain[0] = dsp_pkg::gain_t'(g);
            step(SETTLE);
            // 2 lsb of rotator error through x16, gain and the 2 bit drop
            tol = ((32 * g) >>> dsp_pkg::GAIN_SHIFT) / 4 + 1;
            compare_value("dc tone on ch1", da1_data, tone_code(dc_sample(m, g)), tol);
        end
    endtask

    task automatic test_mixer();
        longint sum;
        mag[0] = 12'sd100;
        mag[1] = 12'sd200;
        mag[2] = -12'sd50;
        mag[3] = 12'sd150;
        sum    = 0;
        for (int k = 0; k < dsp_pkg::N_TONES; k++) begin
            phase_inc[k] = '0;
            gain[k]      = dsp_pkg::gain_t'(UNITY);
            sum          = sum + dc_sample(mag[k], UNITY);
        end
        dac_sel_ch1 = ctrl_pkg::SRC_MIX;
        step(SETTLE);
        // shift 5 and above clip at full scale
        for (int s = 0; s < 8; s++) begin
            final_shift = dsp_pkg::shift_t'(s);
            step(4);
            compare_value("mix on ch1", da1_data,
                          (mix_value(sum, s) + dsp_pkg::DAC_OFFSET) & 64'h3fff, 9 << s);
        end
    endtask

    task automatic test_capture();
        dsp_pkg::mag_t m;
        longint        expected;
        int            cycles;
        m            = dsp_pkg::mag_t'(next_random() >> 20);
        mag[0]       = m;
        gain[0]      = dsp_pkg::gain_t'(UNITY);
        phase_inc[0] = '0;
        cap_sel      = ctrl_pkg::CAP_TONE0;
        step(SETTLE);
        expected = dc_sample(m, UNITY);
        arm_capture(cycles);
        read_capture();
        for (int i = 0; i < ctrl_pkg::CAP_DEPTH; i++)
            compare_value("captured dc tone", cap_copy[i], expected, 32);
        compare_value("done held after readback", cap_done, 1, 0);
        // second arm drops done until the refill ends
        arm_capture(cycles);
    endtask

    task automatic test_rotation();
        dsp_pkg::mag_t m;
        longint        quad_sum;
        int            cycles;
        m            = dsp_pkg::mag_t'(512 + (next_random() >> 22));
        mag[0]       = m;
        gain[0]      = dsp_pkg::gain_t'(UNITY);
        phase_inc[0] = dsp_pkg::phase_t'(1 << 22);
        cap_sel      = ctrl_pkg::CAP_TONE0;
        step(SETTLE);
        arm_capture(cycles);
        read_capture();
        // neighbours are a peak and a near-zero
        compare_value("quarter turn peak",
                      abs_value(cap_copy[0]) + abs_value(cap_copy[1]),
                      dc_sample(m, UNITY), 64);
        for (int k = 0; k < ctrl_pkg::CAP_DEPTH - 2; k++)
            compare_value("half turn apart", cap_copy[k+2], -longint'(cap_copy[k]), 64);
        for (int k = 0; k < ctrl_pkg::CAP_DEPTH - 3; k++) begin
            quad_sum = longint'(cap_copy[k]) + cap_copy[k+1] + cap_copy[k+2] + cap_copy[k+3];
            compare_value("full turn sum", quad_sum, 0, 128);
        end
    endtask

    // ------------------------------
    // sequence and watchdog
    // ------------------------------

    initial begin
        for (int k = 0; k < dsp_pkg::N_TONES; k++) begin
            phase_inc[k] = '0;
            mag[k]       = '0;
            gain[k]      = '0;
        end
        final_shift = '0;
        adc_ch0     = '0;
        adc_ch1     = '0;
        dac_sel_ch1 = ctrl_pkg::SRC_TONE0;
        dac_sel_ch2 = ctrl_pkg::SRC_TONE0;
        cap_sel     = ctrl_pkg::CAP_TONE0;
        cap_arm     = 1'b0;
        cap_idx     = '0;
        step(1);
        test_reset();
        test_adc_passthrough();
        test_dc_tone();
        test_mixer();
        test_capture();
        test_rotation();
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_sys_clk,
    output logic o_rst
);

    // 4 ns period
    initial begin
        o_sys_clk = 1'b0;
        forever #2 o_sys_clk = ~o_sys_clk;
    end

    // reset held over 16 rising edges, released on a falling edge
    initial begin
        o_rst = 1'b1;
        repeat (16) @(posedge o_sys_clk);
        @(negedge o_sys_clk);
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/uberclock_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uberclock_top (
    input  wire logic               i_sys_clk,
    input  wire logic               i_rst,
    // tone settings from the cpu
    input  wire dsp_pkg::phase_t    i_phase_inc [dsp_pkg::N_TONES],
    input  wire dsp_pkg::mag_t      i_mag       [dsp_pkg::N_TONES],
    input  wire dsp_pkg::gain_t     i_gain      [dsp_pkg::N_TONES],
    input  wire dsp_pkg::shift_t    i_final_shift,
    // adc pins
    input  wire dsp_pkg::adc_word_t i_adc_data_ch0,
    input  wire dsp_pkg::adc_word_t i_adc_data_ch1,
    input  wire ctrl_pkg::dac_src_e i_dac_sel_ch1,
    input  wire ctrl_pkg::dac_src_e i_dac_sel_ch2,
    // capture control
    input  wire ctrl_pkg::cap_src_e i_cap_sel,
    input  wire logic               i_cap_arm,
    input  wire ctrl_pkg::cap_idx_t i_cap_idx,
    output logic                    o_ce,
    output dsp_pkg::dac_word_t      o_da1_data,
    output dsp_pkg::dac_word_t      o_da2_data,
    output logic                    o_cap_done,
    output dsp_pkg::sample_t        o_cap_data
);

    dsp_pkg::sample_t   tone [dsp_pkg::N_TONES];
    logic signed [13:0] mix;

    // ------------------------------
    // transmit tones
    // ------------------------------
    tone_bank u_bank (
        .i_sys_clk   (i_sys_clk),
        .i_rst       (i_rst),
        .i_phase_inc (i_phase_inc),
        .i_mag       (i_mag),
        .i_gain      (i_gain),
        .o_ce        (o_ce),
        .o_tone      (tone)
    );

    tone_mixer u_mixer (
        .i_sys_clk     (i_sys_clk),
        .i_rst         (i_rst),
        .i_ce          (o_ce),
        .i_tone        (tone),
        .i_final_shift (i_final_shift),
        .o_mix         (mix)
    );

    // ------------------------------
    // dac and capture
    // ------------------------------
    dac_router u_router (
        .i_sys_clk      (i_sys_clk),
        .i_rst          (i_rst),
        .i_adc_data_ch0 (i_adc_data_ch0),
        .i_adc_data_ch1 (i_adc_data_ch1),
        .i_tone         (tone),
        .i_mix          (mix),
        .i_dac_sel_ch1  (i_dac_sel_ch1),
        .i_dac_sel_ch2  (i_dac_sel_ch2),
        .o_da1_data     (o_da1_data),
        .o_da2_data     (o_da2_data)
    );

    capture_buffer u_capture (
        .i_sys_clk  (i_sys_clk),
        .i_rst      (i_rst),
        .i_ce       (o_ce),
        .i_tone     (tone),
        .i_mix      (mix),
        .i_cap_sel  (i_cap_sel),
        .i_cap_arm  (i_cap_arm),
        .i_cap_idx  (i_cap_idx),
        .o_cap_done (o_cap_done),
        .o_cap_data (o_cap_data)
    );

endmodule

`default_nettype wire

/* logic/capture_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_buffer (
    input  wire logic               i_sys_clk,
    input  wire logic               i_rst,
    input  wire logic               i_ce,
    input  wire dsp_pkg::sample_t   i_tone [dsp_pkg::N_TONES],
    input  wire logic signed [13:0] i_mix,
    input  wire ctrl_pkg::cap_src_e i_cap_sel,
    input  wire logic               i_cap_arm,
    input  wire ctrl_pkg::cap_idx_t i_cap_idx,
    output logic                    o_cap_done,
    output dsp_pkg::sample_t        o_cap_data
);

    ctrl_pkg::cap_state_e state;
    ctrl_pkg::cap_idx_t   wr_idx;
    logic                 arm_q;
    logic                 arm_rise;
    logic                 wr_en;
    dsp_pkg::sample_t     wr_data;
    dsp_pkg::sample_t     mem [ctrl_pkg::CAP_DEPTH];

    assign arm_rise = i_cap_arm & ~arm_q;
    assign wr_en    = (state == ctrl_pkg::CAP_RUN) && i_ce;

    // source pick, the mix sign extends to 16 bits
    always_comb begin
        case (i_cap_sel)
            ctrl_pkg::CAP_TONE0: wr_data = i_tone[0];
            ctrl_pkg::CAP_TONE1: wr_data = i_tone[1];
            ctrl_pkg::CAP_TONE2: wr_data = i_tone[2];
            ctrl_pkg::CAP_TONE3: wr_data = i_tone[3];
            default:             wr_data = i_mix;
        endcase
    end

    // ------------------------------
    // arm / run / full
    // ------------------------------
    // re-arm restarts from any state and clears done
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst) begin
            arm_q  <= 1'b0;
            state  <= ctrl_pkg::CAP_IDLE;
            wr_idx <= '0;
        end else begin
            arm_q <= i_cap_arm;
            if (arm_rise) begin
                state  <= ctrl_pkg::CAP_RUN;
                wr_idx <= '0;
            end else if (wr_en) begin
                wr_idx <= wr_idx + 1'b1;
                // last slot written, hold until the next arm
                if (wr_idx == ctrl_pkg::cap_idx_t'(ctrl_pkg::CAP_DEPTH - 1))
                    state <= ctrl_pkg::CAP_FULL;
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (wr_en)
            mem[wr_idx] <= wr_data;
    end

    assign o_cap_data = mem[i_cap_idx];
    assign o_cap_done = (state == ctrl_pkg::CAP_FULL);

    // outside a run, only an arm edge moves the pointer or starts writing
    assert property (@(posedge i_sys_clk) disable iff (i_rst)
        (state != ctrl_pkg::CAP_RUN) && !arm_rise
            |=> $stable(wr_idx) && (state != ctrl_pkg::CAP_RUN))
        else $error("capture write outside CAP_RUN");

endmodule

`default_nettype wire

/* logic/dac_router.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_router (
    input  wire logic               i_sys_clk,
    input  wire logic               i_rst,
    input  wire dsp_pkg::adc_word_t i_adc_data_ch0,
    input  wire dsp_pkg::adc_word_t i_adc_data_ch1,
    input  wire dsp_pkg::sample_t   i_tone [dsp_pkg::N_TONES],
    input  wire logic signed [13:0] i_mix,
    input  wire ctrl_pkg::dac_src_e i_dac_sel_ch1,
    input  wire ctrl_pkg::dac_src_e i_dac_sel_ch2,
    output dsp_pkg::dac_word_t      o_da1_data,
    output dsp_pkg::dac_word_t      o_da2_data
);

    logic [11:0]        adc_s0;
    logic [11:0]        adc_s1;
    dsp_pkg::dac_word_t cand [8];

    // offset binary to two's complement, msb flip
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst) begin
            adc_s0 <= '0;
            adc_s1 <= '0;
        end else begin
            adc_s0 <= {~i_adc_data_ch0[11], i_adc_data_ch0[10:0]};
            adc_s1 <= {~i_adc_data_ch1[11], i_adc_data_ch1[10:0]};
        end
    end

    // ------------------------------
    // 14 bit candidates by code
    // ------------------------------
    always_comb begin
        // tones keep their top 14 bits
        for (int k = 0; k < dsp_pkg::N_TONES; k++) begin
            cand[k] = i_tone[k][15:2];
        end
        cand[ctrl_pkg::SRC_MIX]  = i_mix;
        cand[ctrl_pkg::SRC_ADC0] = {adc_s0, 2'b00};
        cand[ctrl_pkg::SRC_ADC1] = {adc_s1, 2'b00};
        // spare code, mix again
        cand[7] = i_mix;
    end

    // mid-scale offset, wraps modulo 2^14
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst) begin
            o_da1_data <= dsp_pkg::dac_word_t'(dsp_pkg::DAC_OFFSET);
            o_da2_data <= dsp_pkg::dac_word_t'(dsp_pkg::DAC_OFFSET);
        end else begin
            o_da1_data <= cand[i_dac_sel_ch1] + dsp_pkg::dac_word_t'(dsp_pkg::DAC_OFFSET);
            o_da2_data <= cand[i_dac_sel_ch2] + dsp_pkg::dac_word_t'(dsp_pkg::DAC_OFFSET);
        end
    end

endmodule

`default_nettype wire

/* logic/tone_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_mixer (
    input  wire logic             i_sys_clk,
    input  wire logic             i_rst,
    input  wire logic             i_ce,
    input  wire dsp_pkg::sample_t i_tone [dsp_pkg::N_TONES],
    input  wire dsp_pkg::shift_t  i_final_shift,
    output logic signed [13:0]    o_mix
);

    logic signed [16:0] pair_lo;
    logic signed [16:0] pair_hi;
    logic signed [17:0] sum_all;
    logic signed [20:0] dropped;
    logic signed [20:0] shifted;

    // ------------------------------
    // sum tree
    // ------------------------------
    // first level loads on the strobe, second free-running
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst) begin
            pair_lo <= '0;
            pair_hi <= '0;
            sum_all <= '0;
        end else begin
            if (i_ce) begin
                pair_lo <= i_tone[0] + i_tone[1];
                pair_hi <= i_tone[2] + i_tone[3];
            end
            sum_all <= pair_lo + pair_hi;
        end
    end

    // ------------------------------
    // drop, shift, saturate
    // ------------------------------
    // 21 bits hold the 14 bit drop shifted by up to 7
    assign dropped = sum_all >>> dsp_pkg::MIX_DROP;
    assign shifted = dropped <<< i_final_shift;

    // clip instead of wrapping on large shifts
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst)
            o_mix <= '0;
        else if (shifted > 21'sd8191)
            o_mix <= 14'sd8191;
        else if (shifted < -21'sd8192)
            o_mix <= -14'sd8192;
        else
            o_mix <= shifted[13:0];
    end

endmodule

`default_nettype wire

/* logic/tone_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_bank (
    input  wire logic            i_sys_clk,
    input  wire logic            i_rst,
    input  wire dsp_pkg::phase_t i_phase_inc [dsp_pkg::N_TONES],
    input  wire dsp_pkg::mag_t   i_mag       [dsp_pkg::N_TONES],
    input  wire dsp_pkg::gain_t  i_gain      [dsp_pkg::N_TONES],
    output logic                 o_ce,
    output dsp_pkg::sample_t     o_tone      [dsp_pkg::N_TONES]
);

    logic [$clog2(dsp_pkg::DECIM)-1:0] div_cnt;

    // ------------------------------
    // sample strobe
    // ------------------------------
    // first pulse DECIM cycles after reset release
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst) begin
            div_cnt <= '0;
            o_ce    <= 1'b0;
        end else begin
            o_ce <= (div_cnt == dsp_pkg::DECIM - 1);
            if (div_cnt == dsp_pkg::DECIM - 1)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------
    // tone generators
    // ------------------------------
    for (genvar k = 0; k < dsp_pkg::N_TONES; k++) begin : g_tone
        tone_generator u_tone (
            .i_sys_clk   (i_sys_clk),
            .i_rst       (i_rst),
            .i_ce        (o_ce),
            .i_phase_inc (i_phase_inc[k]),
            .i_mag       (i_mag[k]),
            .i_gain      (i_gain[k]),
            .o_sample    (o_tone[k])
        );
    end

    // strobe spacing, no two pulses within DECIM cycles
    assert property (@(posedge i_sys_clk) disable iff (i_rst)
        o_ce |=> !o_ce [*(dsp_pkg::DECIM-1)])
        else $error("sample strobe spacing below DECIM");

endmodule

`default_nettype wire

/* logic/tone_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_generator (
    input  wire logic            i_sys_clk,
    input  wire logic            i_rst,
    input  wire logic            i_ce,
    input  wire dsp_pkg::phase_t i_phase_inc,
    input  wire dsp_pkg::mag_t   i_mag,
    input  wire dsp_pkg::gain_t  i_gain,
    output dsp_pkg::sample_t     o_sample
);

    dsp_pkg::phase_t    phase_acc;
    dsp_pkg::mag_t      cos_x;
    logic signed [48:0] gained;

    // phase steps once per sample strobe
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst)
            phase_acc <= '0;
        else if (i_ce)
            phase_acc <= phase_acc + i_phase_inc;
    end

    // rotator runs every cycle, only the cosine leg is used
    cordic_rotator u_rot (
        .i_sys_clk (i_sys_clk),
        .i_rst     (i_rst),
        .i_mag     (i_mag),
        .i_phase   (phase_acc),
        .o_x       (cos_x),
        .o_y       ()
    );

    // x16 lifts the 12 bit tone into the 16 bit frame
    // gain is unsigned, so a zero msb keeps it positive
    assign gained = $signed({cos_x, 4'b0000}) * $signed({1'b0, i_gain});

    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst)
            o_sample <= '0;
        else
            o_sample <= dsp_pkg::sample_t'(gained >>> dsp_pkg::GAIN_SHIFT);
    end

endmodule

`default_nettype wire

/* logic/cordic_rotator.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator (
    input  wire logic            i_sys_clk,
    input  wire logic            i_rst,
    input  wire dsp_pkg::mag_t   i_mag,
    input  wire dsp_pkg::phase_t i_phase,
    output dsp_pkg::mag_t        o_x,
    output dsp_pkg::mag_t        o_y
);

    // atan(2^-i) in units of 2^-24 turn
    localparam dsp_pkg::phase_t ATAN_TBL [dsp_pkg::CORDIC_STAGES] = '{
        24'd2097152, 24'd1238021, 24'd654136, 24'd332050,
        24'd166669,  24'd83416,   24'd41718,  24'd20860,
        24'd10430,   24'd5215,    24'd2608,   24'd1304,
        24'd652,     24'd326,     24'd163,    24'd81
    };

    logic signed [dsp_pkg::CORDIC_WW-1:0] xs [dsp_pkg::CORDIC_STAGES+1];
    logic signed [dsp_pkg::CORDIC_WW-1:0] ys [dsp_pkg::CORDIC_STAGES+1];
    logic signed [23:0]                   zs [dsp_pkg::CORDIC_STAGES+1];
    logic signed [dsp_pkg::CORDIC_WW-1:0] mag_w;
    logic signed [37:0]                   x_prod;
    logic signed [37:0]                   y_prod;

    // 7 fraction bits, one bit left for the ~1.647 growth
    assign mag_w = {{(dsp_pkg::CORDIC_WW-19){i_mag[11]}}, i_mag, 7'b0};

    // ------------------------------
    // quadrant fold
    // ------------------------------
    // top two phase bits pre-rotate by multiples of 90 deg,
    // residual angle stays in [0, 90)
    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst) begin
            xs[0] <= '0;
            ys[0] <= '0;
            zs[0] <= '0;
        end else begin
            zs[0] <= {2'b00, i_phase[21:0]};
            case (i_phase[23:22])
                2'd0: begin
                    xs[0] <= mag_w;
                    ys[0] <= '0;
                end
                2'd1: begin
                    xs[0] <= '0;
                    ys[0] <= mag_w;
                end
                2'd2: begin
                    xs[0] <= -mag_w;
                    ys[0] <= '0;
                end
                default: begin
                    xs[0] <= '0;
                    ys[0] <= -mag_w;
                end
            endcase
        end
    end

    // ------------------------------
    // rotation stages
    // ------------------------------
    for (genvar i = 0; i < dsp_pkg::CORDIC_STAGES; i++) begin : g_stage
        always_ff @(posedge i_sys_clk or posedge i_rst) begin
            if (i_rst) begin
                xs[i+1] <= '0;
                ys[i+1] <= '0;
                zs[i+1] <= '0;
            end else if (zs[i] >= 0) begin
                // residual left, turn counter-clockwise
                xs[i+1] <= xs[i] - (ys[i] >>> i);
                ys[i+1] <= ys[i] + (xs[i] >>> i);
                zs[i+1] <= zs[i] - $signed(ATAN_TBL[i]);
            end else begin
                xs[i+1] <= xs[i] + (ys[i] >>> i);
                ys[i+1] <= ys[i] - (xs[i] >>> i);
                zs[i+1] <= zs[i] + $signed(ATAN_TBL[i]);
            end
        end
    end

    // ------------------------------
    // gain compensation
    // ------------------------------
    // 1/K = 0.60725, as 39797 / 2^16
    assign x_prod = xs[dsp_pkg::CORDIC_STAGES] * 18'sd39797;
    assign y_prod = ys[dsp_pkg::CORDIC_STAGES] * 18'sd39797;

    // drop 16 gain bits and 7 fraction bits, round half up, clip
    function automatic dsp_pkg::mag_t round_sat(input logic signed [37:0] p);
        logic signed [37:0] r;
        r = (p + (38'sd1 <<< 22)) >>> 23;
        if (r > 38'sd2047)
            return 12'sd2047;
        else if (r < -38'sd2048)
            return -12'sd2048;
        return r[11:0];
    endfunction

    always_ff @(posedge i_sys_clk or posedge i_rst) begin
        if (i_rst) begin
            o_x <= '0;
            o_y <= '0;
        end else begin
            o_x <= round_sat(x_prod);
            o_y <= round_sat(y_prod);
        end
    end

    // zero magnitude held over the whole pipe flushes to zero
    assert property (@(posedge i_sys_clk) disable iff (i_rst)
        (i_mag == '0) [*dsp_pkg::CORDIC_LATENCY] |=> (o_x == '0) && (o_y == '0))
        else $error("cordic output nonzero after zero magnitude");

endmodule

`default_nettype wire

/* logic/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // ------------------------------
    // cpu select codes
    // ------------------------------

    // dac source, codes above SRC_ADC1 fall back to the mix
    typedef enum logic [2:0] {
        SRC_TONE0 = 3'd0,
        SRC_TONE1 = 3'd1,
        SRC_TONE2 = 3'd2,
        SRC_TONE3 = 3'd3,
        SRC_MIX   = 3'd4,
        SRC_ADC0  = 3'd5,
        SRC_ADC1  = 3'd6
    } dac_src_e;

    // capture source
    typedef enum logic [2:0] {
        CAP_TONE0 = 3'd0,
        CAP_TONE1 = 3'd1,
        CAP_TONE2 = 3'd2,
        CAP_TONE3 = 3'd3,
        CAP_MIX   = 3'd4
    } cap_src_e;

    // ------------------------------
    // capture memory
    // ------------------------------

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_RUN,
        CAP_FULL
    } cap_state_e;

    localparam int CAP_DEPTH = 512;
    typedef logic [8:0] cap_idx_t;

endpackage

`default_nettype wire

/* logic/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

    // ------------------------------
    // datapath word types
    // ------------------------------

    // tone phase and increment, one turn is 2^24
    typedef logic [23:0] phase_t;
    // programmed tone magnitude
    typedef logic signed [11:0] mag_t;
    // unsigned tone gain, 2^30 is unity
    typedef logic [31:0] gain_t;
    // gained tone sample
    typedef logic signed [15:0] sample_t;
    // code towards the dac pins
    typedef logic [13:0] dac_word_t;
    // raw adc code, offset binary
    typedef logic [11:0] adc_word_t;
    // left shift after the sum tree drop
    typedef logic [2:0] shift_t;

    // ------------------------------
    // pipeline and rate constants
    // ------------------------------

    localparam int N_TONES        = 4;
    // cordic rotation stages and working width
    localparam int CORDIC_STAGES  = 16;
    localparam int CORDIC_WW      = 20;
    // fold register + stages + gain compensation
    localparam int CORDIC_LATENCY = CORDIC_STAGES + 2;
    localparam int GAIN_SHIFT     = 30;
    // 18 bit sum down to 14 bits
    localparam int MIX_DROP       = 4;
    // sys_clk cycles per sample strobe
    localparam int DECIM          = 8;
    // mid-scale for offset binary
    localparam int DAC_OFFSET     = 8192;

endpackage

`default_nettype wire
